// ==== verilog/core_pkg.sv ====
// Core package.
// Widths, opcodes, ALU codes and the instruction formats shared by the core.
`default_nettype none

package core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int ALU_OP_W   = 3;

    localparam logic [ALU_OP_W-1:0] ALU_ADD    = 3'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB    = 3'd1;
    localparam logic [ALU_OP_W-1:0] ALU_AND    = 3'd2;
    localparam logic [ALU_OP_W-1:0] ALU_OR     = 3'd3;
    localparam logic [ALU_OP_W-1:0] ALU_XOR    = 3'd4;
    localparam logic [ALU_OP_W-1:0] ALU_PASS_B = 3'd5; // Used by LUI.

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [2:0] F3_SW      = 3'b010;
    localparam logic [6:0] F7_SUB     = 7'b0100000;

    localparam logic [XLEN-1:0] INSTR_BYTES = 32'd4;
    localparam logic [XLEN-1:0] RESET_PC    = 32'h0000_0000;
    localparam logic [3:0]      WORD_STROBE = 4'b1111;

    // The five formats overlay the same 32-bit word.
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_format_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_format_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_format_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_format_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_format_t;

    typedef union packed {
        r_format_t r;
        i_format_t i;
        s_format_t s;
        b_format_t b;
        u_format_t u;
    } instr_u;

endpackage

`default_nettype wire

// ==== verilog/issue_if.sv ====
// Issue interface.
// Carries one decoded instruction from decode to execute.
`timescale 1ns/100ps
`default_nettype none

interface issue_if;

    logic [core_pkg::ALU_OP_W-1:0]   alu_op;
    logic [core_pkg::XLEN-1:0]       operand_a;
    logic [core_pkg::XLEN-1:0]       operand_b;
    logic [core_pkg::REG_ADDR_W-1:0] rd;
    logic                            rd_write;
    logic                            is_store;
    logic [core_pkg::XLEN-1:0]       store_data; // Also the second branch operand.
    logic                            is_branch;
    logic                            branch_on_equal;
    logic [core_pkg::XLEN-1:0]       branch_target;

    modport decode_mp (
        output alu_op, operand_a, operand_b, rd, rd_write,
        output is_store, store_data, is_branch, branch_on_equal, branch_target
    );

    modport execute_mp (
        input alu_op, operand_a, operand_b, rd, rd_write,
        input is_store, store_data, is_branch, branch_on_equal, branch_target
    );

endinterface

`default_nettype wire

// ==== verilog/pipeline_control.sv ====
// Pipeline control.
// Keeps the decode and execute valid bits and flushes them on a taken branch.
`timescale 1ns/100ps
`default_nettype none

module pipeline_control (
    input  logic clk,
    input  logic reset,
    input  logic stall_i,
    input  logic redirect_i,
    output logic advance_o,
    output logic decode_valid_o,
    output logic exec_valid_o
);

    // Every stage moves together unless the outside world stalls us.
    assign advance_o = !stall_i;

    always_ff @(posedge clk) begin
        if (reset) begin
            decode_valid_o <= 1'b0;
            exec_valid_o   <= 1'b0;
        end
        else if (advance_o) begin
            if (redirect_i) begin
                // Both younger instructions came from the wrong path.
                decode_valid_o <= 1'b0;
                exec_valid_o   <= 1'b0;
            end
            else begin
                decode_valid_o <= 1'b1;           // The next word is on the correct path.
                exec_valid_o   <= decode_valid_o;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/fetch_unit.sv ====
// Fetch unit.
// Holds the program counter that addresses the instruction memory.
`timescale 1ns/100ps
`default_nettype none

module fetch_unit (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      advance_i,
    input  logic                      redirect_i,
    input  logic [core_pkg::XLEN-1:0] redirect_target_i,
    output logic [core_pkg::XLEN-1:0] instruction_address_o,
    output logic [core_pkg::XLEN-1:0] pc_o
);

    always_ff @(posedge clk) begin
        if (reset) begin
            instruction_address_o <= core_pkg::RESET_PC;
        end
        else if (advance_i) begin
            if (redirect_i) begin
                instruction_address_o <= redirect_target_i;
            end
            else begin
                instruction_address_o <= instruction_address_o + core_pkg::INSTR_BYTES;
            end
        end
    end

    // The word for this address comes back one cycle later, so pc_o trails by one.
    always_ff @(posedge clk) begin
        if (advance_i) pc_o <= instruction_address_o;
    end

endmodule

`default_nettype wire

// ==== verilog/register_file.sv ====
// Register file.
// Thirty-two words, two combinational read ports and one write port.
`timescale 1ns/100ps
`default_nettype none

module register_file (
    input  logic                            clk,
    input  logic [core_pkg::REG_ADDR_W-1:0] rs1_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] rs2_i,
    input  logic                            wr_en_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] wr_addr_i,
    input  logic [core_pkg::XLEN-1:0]       wr_data_i,
    output logic [core_pkg::XLEN-1:0]       rs1_data_o,
    output logic [core_pkg::XLEN-1:0]       rs2_data_o
);

    logic [core_pkg::XLEN-1:0] regs [core_pkg::NUM_REGS];

    always_ff @(posedge clk) begin
        if (wr_en_i) regs[wr_addr_i] <= wr_data_i;
    end

    // Register 0 reads as zero whatever was written to it.
    assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

`default_nettype wire

// ==== verilog/decode_unit.sv ====
// Decode unit.
// Decodes the instruction word, picks the immediate, forwards writeback data
// over the register file values and registers the issue payload.
`timescale 1ns/100ps
`default_nettype none

module decode_unit (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            advance_i,
    input  logic                            decode_valid_i,
    input  logic [core_pkg::XLEN-1:0]       instruction_i,
    input  logic [core_pkg::XLEN-1:0]       pc_i,
    input  logic                            wb_en_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] wb_rd_i,
    input  logic [core_pkg::XLEN-1:0]       wb_data_i,
    output logic [core_pkg::REG_ADDR_W-1:0] rs1_o,
    output logic [core_pkg::REG_ADDR_W-1:0] rs2_o,
    input  logic [core_pkg::XLEN-1:0]       rs1_data_i,
    input  logic [core_pkg::XLEN-1:0]       rs2_data_i,
    issue_if.decode_mp                      issue
);

    core_pkg::instr_u                instr;
    logic [core_pkg::XLEN-1:0]       rs1_val;
    logic [core_pkg::XLEN-1:0]       rs2_val;
    logic [core_pkg::XLEN-1:0]       imm_i;
    logic [core_pkg::XLEN-1:0]       imm_s;
    logic [core_pkg::XLEN-1:0]       imm_b;
    logic [core_pkg::XLEN-1:0]       imm_u;
    logic [core_pkg::ALU_OP_W-1:0]   alu_op;
    logic [core_pkg::XLEN-1:0]       op_b;
    logic                            rd_write;
    logic                            is_store;
    logic                            is_branch;

    assign instr = instruction_i;
    assign rs1_o = instr.r.rs1; // Source fields sit in the same place in every format.
    assign rs2_o = instr.r.rs2;

    // The instruction in execute writes its result this cycle; take it directly.
    assign rs1_val = (wb_en_i && wb_rd_i == rs1_o) ? wb_data_i : rs1_data_i;
    assign rs2_val = (wb_en_i && wb_rd_i == rs2_o) ? wb_data_i : rs2_data_i;

    assign imm_i = {{(core_pkg::XLEN-12){instr.i.imm[11]}}, instr.i.imm};
    assign imm_s = {{(core_pkg::XLEN-12){instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
    assign imm_b = {{(core_pkg::XLEN-13){instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                    instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
    assign imm_u = {instr.u.imm, 12'h000};

    always_comb begin
        alu_op    = core_pkg::ALU_ADD;
        op_b      = rs2_val;
        rd_write  = 1'b0;
        is_store  = 1'b0;
        is_branch = 1'b0;
        case (instr.r.opcode)
            core_pkg::OPC_OP: begin
                rd_write = 1'b1;
                case (instr.r.funct3)
                    core_pkg::F3_ADD_SUB: begin
                        if (instr.r.funct7 == core_pkg::F7_SUB) alu_op = core_pkg::ALU_SUB;
                    end
                    core_pkg::F3_XOR: alu_op = core_pkg::ALU_XOR;
                    core_pkg::F3_OR:  alu_op = core_pkg::ALU_OR;
                    core_pkg::F3_AND: alu_op = core_pkg::ALU_AND;
                    default:          rd_write = 1'b0;
                endcase
                // Only SUB may carry a nonzero funct7.
                if (instr.r.funct7 != '0 && !(instr.r.funct7 == core_pkg::F7_SUB &&
                                              instr.r.funct3 == core_pkg::F3_ADD_SUB)) begin
                    rd_write = 1'b0;
                end
            end
            core_pkg::OPC_OP_IMM: begin
                rd_write = (instr.i.funct3 == core_pkg::F3_ADD_SUB); // ADDI only.
                op_b     = imm_i;
            end
            core_pkg::OPC_LUI: begin
                rd_write = 1'b1;
                alu_op   = core_pkg::ALU_PASS_B;
                op_b     = imm_u;
            end
            core_pkg::OPC_BRANCH: begin
                is_branch = (instr.b.funct3 == core_pkg::F3_BEQ) ||
                            (instr.b.funct3 == core_pkg::F3_BNE);
            end
            core_pkg::OPC_STORE: begin
                is_store = (instr.s.funct3 == core_pkg::F3_SW);
                op_b     = imm_s;
            end
            default: ;
        endcase
    end

    // Control flags are cleared by reset and never set for a flushed slot.
    always_ff @(posedge clk) begin
        if (reset) begin
            issue.rd_write  <= 1'b0;
            issue.is_store  <= 1'b0;
            issue.is_branch <= 1'b0;
        end
        else if (advance_i) begin
            issue.rd_write  <= rd_write && decode_valid_i;
            issue.is_store  <= is_store && decode_valid_i;
            issue.is_branch <= is_branch && decode_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (advance_i) begin
            issue.alu_op          <= alu_op;
            issue.operand_a       <= rs1_val;
            issue.operand_b       <= op_b;
            issue.rd              <= instr.r.rd;
            issue.store_data      <= rs2_val;
            issue.branch_on_equal <= (instr.b.funct3 == core_pkg::F3_BEQ);
            issue.branch_target   <= pc_i + imm_b;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/execute_unit.sv ====
// Execute unit.
// ALU, branch compare and writeback, plus the registered store port.
`timescale 1ns/100ps
`default_nettype none

module execute_unit (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            advance_i,
    input  logic                            exec_valid_i,
    issue_if.execute_mp                     issue,
    output logic                            wb_en_o,
    output logic [core_pkg::REG_ADDR_W-1:0] wb_rd_o,
    output logic [core_pkg::XLEN-1:0]       wb_data_o,
    output logic                            redirect_o,
    output logic [core_pkg::XLEN-1:0]       redirect_target_o,
    output logic [3:0]                      mem_write_enable_o,
    output logic [core_pkg::XLEN-1:0]       mem_address_o,
    output logic [core_pkg::XLEN-1:0]       mem_data_o
);

    logic [core_pkg::XLEN-1:0] sum;
    logic                      operands_equal;

    // One adder serves ADD, ADDI and the store address.
    assign sum = issue.operand_a + issue.operand_b;

    always_comb begin
        case (issue.alu_op)
            core_pkg::ALU_SUB:    wb_data_o = issue.operand_a - issue.operand_b;
            core_pkg::ALU_AND:    wb_data_o = issue.operand_a & issue.operand_b;
            core_pkg::ALU_OR:     wb_data_o = issue.operand_a | issue.operand_b;
            core_pkg::ALU_XOR:    wb_data_o = issue.operand_a ^ issue.operand_b;
            core_pkg::ALU_PASS_B: wb_data_o = issue.operand_b;
            default:              wb_data_o = sum;
        endcase
    end

    assign wb_rd_o = issue.rd;
    // No write while stalled, and x0 is never written.
    assign wb_en_o = exec_valid_i && advance_i && issue.rd_write && (issue.rd != '0);

    // Branches compare rs1 against rs2, which travels in store_data.
    assign operands_equal    = (issue.operand_a == issue.store_data);
    assign redirect_o        = exec_valid_i && issue.is_branch &&
                               (operands_equal == issue.branch_on_equal);
    assign redirect_target_o = issue.branch_target;

    // The strobe is rewritten every cycle so it lasts a single cycle at most.
    always_ff @(posedge clk) begin
        if (reset) begin
            mem_write_enable_o <= '0;
        end
        else if (advance_i && exec_valid_i && issue.is_store) begin
            mem_write_enable_o <= core_pkg::WORD_STROBE;
        end
        else begin
            mem_write_enable_o <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (advance_i) begin
            mem_address_o <= {sum[core_pkg::XLEN-1:2], 2'b00}; // Word aligned.
            mem_data_o    <= issue.store_data;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/riscv_core.sv ====
// Three-stage integer core top level.
// Connects control, fetch, decode, register file and execute.
`timescale 1ns/100ps
`default_nettype none

module riscv_core (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      stall_i,
    input  logic [core_pkg::XLEN-1:0] instruction_i,
    output logic [core_pkg::XLEN-1:0] instruction_address_o,
    output logic [3:0]                mem_write_enable_o,
    output logic [core_pkg::XLEN-1:0] mem_address_o,
    output logic [core_pkg::XLEN-1:0] mem_data_o
);

    logic                            advance;
    logic                            decode_valid;
    logic                            exec_valid;
    logic                            redirect;
    logic [core_pkg::XLEN-1:0]       redirect_target;
    logic [core_pkg::XLEN-1:0]       pc_decode;
    logic [core_pkg::REG_ADDR_W-1:0] rs1;
    logic [core_pkg::REG_ADDR_W-1:0] rs2;
    logic [core_pkg::XLEN-1:0]       rs1_data;
    logic [core_pkg::XLEN-1:0]       rs2_data;
    logic                            wb_en;
    logic [core_pkg::REG_ADDR_W-1:0] wb_rd;
    logic [core_pkg::XLEN-1:0]       wb_data;

    issue_if issue ();

    pipeline_control u_control (
        .clk            (clk),
        .reset          (reset),
        .stall_i        (stall_i),
        .redirect_i     (redirect),
        .advance_o      (advance),
        .decode_valid_o (decode_valid),
        .exec_valid_o   (exec_valid)
    );

    fetch_unit u_fetch (
        .clk                   (clk),
        .reset                 (reset),
        .advance_i             (advance),
        .redirect_i            (redirect),
        .redirect_target_i     (redirect_target),
        .instruction_address_o (instruction_address_o),
        .pc_o                  (pc_decode)
    );

    decode_unit u_decode (
        .clk            (clk),
        .reset          (reset),
        .advance_i      (advance),
        .decode_valid_i (decode_valid),
        .instruction_i  (instruction_i),
        .pc_i           (pc_decode),
        .wb_en_i        (wb_en),
        .wb_rd_i        (wb_rd),
        .wb_data_i      (wb_data),
        .rs1_o          (rs1),
        .rs2_o          (rs2),
        .rs1_data_i     (rs1_data),
        .rs2_data_i     (rs2_data),
        .issue          (issue.decode_mp)
    );

    register_file u_regs (
        .clk        (clk),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .wr_en_i    (wb_en),
        .wr_addr_i  (wb_rd),
        .wr_data_i  (wb_data),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    execute_unit u_execute (
        .clk                (clk),
        .reset              (reset),
        .advance_i          (advance),
        .exec_valid_i       (exec_valid),
        .issue              (issue.execute_mp),
        .wb_en_o            (wb_en),
        .wb_rd_o            (wb_rd),
        .wb_data_o          (wb_data),
        .redirect_o         (redirect),
        .redirect_target_o  (redirect_target),
        .mem_write_enable_o (mem_write_enable_o),
        .mem_address_o      (mem_address_o),
        .mem_data_o         (mem_data_o)
    );

endmodule

`default_nettype wire

// ==== sim/core_tb.sv ====
// Testbench for the three-stage integer core.
// Runs a program from a ROM against a reference model, first without and then
// with random stall, and checks every store on the memory write port.
`timescale 1ns/100ps
`default_nettype none

module core_tb;

    localparam int          CLK_PERIOD    = 40;
    localparam int          STORE_TIMEOUT = 200; // Cycles allowed per store.
    localparam int          MODEL_STEPS   = 200;
    localparam int          ROM_WORDS     = 64;
    localparam logic [31:0] LFSR_SEED     = 32'd66214;

    logic        clk;
    logic        reset;
    logic        stall_i       = 1'b0;
    logic [31:0] instruction_i = '0;
    logic [31:0] instruction_address_o;
    logic [3:0]  mem_write_enable_o;
    logic [31:0] mem_address_o;
    logic [31:0] mem_data_o;

    logic [31:0] rom [ROM_WORDS];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] lfsr         = LFSR_SEED;
    logic        random_stall = 1'b0;
    logic        was_stalled  = 1'b0;
    logic        was_reset    = 1'b0;
    logic [31:0] last_address = '0;
    int          stores_seen  = 0;

    riscv_core DUT (
        .clk                   (clk),
        .reset                 (reset),
        .stall_i               (stall_i),
        .instruction_i         (instruction_i),
        .instruction_address_o (instruction_address_o),
        .mem_write_enable_o    (mem_write_enable_o),
        .mem_address_o         (mem_address_o),
        .mem_data_o            (mem_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic report_error(string what);
        $display("%s", what);
        $display("Regression failed");
        $fatal(1, "Stopped at the first error.");
    endtask

    task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] want);
        report_error($sformatf("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, want));
    endtask

    // Galois LFSR with taps 32, 30, 26 and 25.
    function automatic logic [31:0] lfsr_next(logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'hA300_0000) : (state >> 1);
    endfunction

    function automatic logic [31:0] r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, core_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] addi(logic [11:0] imm, logic [4:0] rs1, logic [4:0] rd);
        return {imm, rs1, core_pkg::F3_ADD_SUB, rd, core_pkg::OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] sw(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, core_pkg::F3_SW, imm[4:0], core_pkg::OPC_STORE};
    endfunction

    function automatic logic [31:0] branch(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], core_pkg::OPC_BRANCH};
    endfunction

    task automatic load_program();
        // Unused words hold their index over a zero opcode and decode as no-ops.
        for (int i = 0; i < ROM_WORDS; i++) rom[i] = {25'(i), 7'h00};
        rom[0]  = {20'h12345, 5'd1, core_pkg::OPC_LUI};
        rom[1]  = addi(12'h100, 5'd0, 5'd2);                 // Store base in x2.
        rom[2]  = sw(12'd0, 5'd1, 5'd2);
        rom[3]  = addi(12'h678, 5'd1, 5'd1);
        rom[4]  = sw(12'd4, 5'd1, 5'd2);
        rom[5]  = r_type(7'h00, 5'd1, 5'd1, core_pkg::F3_ADD_SUB, 5'd3);
        rom[6]  = sw(12'd8, 5'd3, 5'd2);
        rom[7]  = r_type(core_pkg::F7_SUB, 5'd1, 5'd3, core_pkg::F3_ADD_SUB, 5'd4);
        rom[8]  = sw(12'd12, 5'd4, 5'd2);
        rom[9]  = r_type(7'h00, 5'd3, 5'd4, core_pkg::F3_AND, 5'd5);
        rom[10] = r_type(7'h00, 5'd1, 5'd5, core_pkg::F3_OR, 5'd6);
        rom[11] = r_type(7'h00, 5'd3, 5'd6, core_pkg::F3_XOR, 5'd7);
        rom[12] = sw(12'd16, 5'd7, 5'd2);
        rom[13] = addi(12'd5, 5'd1, 5'd0);                   // Write to x0.
        rom[14] = sw(12'd20, 5'd0, 5'd2);
        rom[15] = sw(12'd24, 5'd6, 5'd2);                    // Back-to-back stores.
        rom[16] = branch(13'd12, 5'd4, 5'd1, core_pkg::F3_BEQ);
        rom[17] = sw(12'd28, 5'd5, 5'd2);
        rom[18] = sw(12'd32, 5'd5, 5'd2);
        rom[19] = branch(13'd12, 5'd3, 5'd1, core_pkg::F3_BNE);
        rom[20] = sw(12'd36, 5'd3, 5'd2);
        rom[21] = addi(12'h044, 5'd0, 5'd2);
        rom[22] = branch(13'd12, 5'd3, 5'd1, core_pkg::F3_BEQ); // Not taken.
        rom[23] = branch(13'd8, 5'd4, 5'd1, core_pkg::F3_BNE); // Not taken.
        rom[24] = sw(12'd40, 5'd5, 5'd2);
        rom[25] = 32'hFFFF_FFFF;
        rom[26] = addi(12'hFFC, 5'd7, 5'd8);
        rom[27] = sw(12'd44, 5'd8, 5'd2);
        rom[28] = branch(13'd0, 5'd0, 5'd0, core_pkg::F3_BEQ); // Loops on itself.
    endtask

    // Executes the program in order and records the stores it should make.
    task automatic run_model();
        logic [31:0] regs [32];
        logic [31:0] pc;
        logic [31:0] pc_next;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] result;
        logic        writes;
        logic        halted;
        int          steps;
        for (int r = 0; r < 32; r++) regs[r] = '0;
        pc     = core_pkg::RESET_PC;
        halted = 1'b0;
        steps  = 0;
        while (!halted && steps < MODEL_STEPS) begin
            w       = rom[pc[7:2]];
            a       = regs[w[19:15]];
            b       = regs[w[24:20]];
            writes  = 1'b0;
            result  = '0;
            pc_next = pc + 32'd4;
            case (w[6:0])
                core_pkg::OPC_OP: begin
                    writes = 1'b1;
                    case ({w[31:25], w[14:12]})
                        {7'h00, core_pkg::F3_ADD_SUB}:    result = a + b;
                        {core_pkg::F7_SUB, 3'b000}:       result = a - b;
                        {7'h00, core_pkg::F3_XOR}:        result = a ^ b;
                        {7'h00, core_pkg::F3_OR}:         result = a | b;
                        {7'h00, core_pkg::F3_AND}:        result = a & b;
                        default:                          writes = 1'b0;
                    endcase
                end
                core_pkg::OPC_OP_IMM: begin
                    writes = (w[14:12] == core_pkg::F3_ADD_SUB);
                    result = a + {{20{w[31]}}, w[31:20]};
                end
                core_pkg::OPC_LUI: begin
                    writes = 1'b1;
                    result = {w[31:12], 12'h000};
                end
                core_pkg::OPC_BRANCH: begin
                    imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                    if ((w[14:12] == core_pkg::F3_BEQ && a == b) ||
                        (w[14:12] == core_pkg::F3_BNE && a != b)) begin
                        halted  = (imm == '0);
                        pc_next = pc + imm;
                    end
                end
                core_pkg::OPC_STORE: begin
                    if (w[14:12] == core_pkg::F3_SW) begin
                        imm = {{20{w[31]}}, w[31:25], w[11:7]};
                        exp_addr.push_back((a + imm) & ~32'h3);
                        exp_data.push_back(b);
                    end
                end
                default: ;
            endcase
            if (writes && w[11:7] != 5'd0) regs[w[11:7]] = result;
            pc = pc_next;
            steps++;
        end
    endtask

    // Instruction memory with one cycle of latency that holds its word under stall.
    always @(posedge clk) begin
        if (!stall_i) instruction_i <= rom[instruction_address_o[7:2]];
    end

    always @(posedge clk) begin
        if (random_stall) begin
            lfsr    = lfsr_next(lfsr); // One step for the one bit taken.
            stall_i <= lfsr[0];
        end
        else begin
            stall_i <= 1'b0;
        end
    end

    // Outputs settle after the rising edge, so they are checked on the falling edge.
    always @(negedge clk) begin
        // was_reset is the level the DUT sampled at the rising edge just before.
        if (was_reset) begin
            assert (mem_write_enable_o == '0)
                else report_mismatch("mem_write_enable_o", 32'(mem_write_enable_o), '0);
            assert (instruction_address_o == core_pkg::RESET_PC)
                else report_mismatch("instruction_address_o", instruction_address_o,
                                     core_pkg::RESET_PC);
        end
        if (was_stalled) begin
            assert (mem_write_enable_o == '0)
                else report_error("A store pulse followed a stalled cycle.");
            assert (instruction_address_o == last_address)
                else report_mismatch("instruction_address_o", instruction_address_o,
                                     last_address);
        end
        if (reset) stores_seen = 0;
        else if (mem_write_enable_o != '0) begin
            assert (mem_write_enable_o == core_pkg::WORD_STROBE)
                else report_mismatch("mem_write_enable_o", 32'(mem_write_enable_o),
                                     32'(core_pkg::WORD_STROBE));
            assert (mem_address_o[1:0] == 2'b00)
                else report_error("A store address is not word aligned.");
            assert (stores_seen < exp_addr.size())
                else report_error("A store appeared beyond the expected list.");
            assert (mem_address_o == exp_addr[stores_seen])
                else report_mismatch("mem_address_o", mem_address_o, exp_addr[stores_seen]);
            assert (mem_data_o == exp_data[stores_seen])
                else report_mismatch("mem_data_o", mem_data_o, exp_data[stores_seen]);
            stores_seen++;
        end
        was_stalled  = stall_i;
        was_reset    = reset;
        last_address = instruction_address_o;
    end

    task automatic hold_reset();
        repeat (3) @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic wait_for_stores();
        int waited;
        for (int k = 0; k < exp_addr.size(); k++) begin
            waited = 0;
            while (stores_seen <= k) begin
                @(posedge clk);
                waited++;
                if (waited > STORE_TIMEOUT)
                    report_error($sformatf("Timed out waiting for store %0d.", k));
            end
        end
    endtask

    initial begin
        reset = 1'b1;
        load_program();
        run_model();
        hold_reset();
        wait_for_stores();
        repeat (20) @(posedge clk); // Idle time in which no extra store may appear.
        // Second pass runs the same program under random stall.
        reset <= 1'b1;
        hold_reset();
        random_stall <= 1'b1;
        wait_for_stores();
        repeat (20) @(posedge clk);
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
verilog/core_pkg.sv
verilog/issue_if.sv
verilog/pipeline_control.sv
verilog/fetch_unit.sv
verilog/register_file.sv
verilog/decode_unit.sv
verilog/execute_unit.sv
verilog/riscv_core.sv
sim/core_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f filelist.f --top-module core_tb -Mdir obj_dir -o core_tb
	./obj_dir/core_tb

clean:
	rm -rf obj_dir
